// File: verilog/vid_regs_pkg.sv
`default_nettype none

package vid_regs_pkg;

    localparam int coord_w   = 13;              // Every timing field
    localparam int div_w     = 6;               // Pixel divider
    localparam int reg_off_w = 8;               // Decoded offset bits

    // Register byte offsets
    localparam logic [reg_off_w-1:0] reg_ctrl    = 8'h00;
    localparam logic [reg_off_w-1:0] reg_h1      = 8'h28;
    localparam logic [reg_off_w-1:0] reg_h2      = 8'h30;
    localparam logic [reg_off_w-1:0] reg_v1      = 8'h38;
    localparam logic [reg_off_w-1:0] reg_v2      = 8'h40;
    localparam logic [reg_off_w-1:0] reg_base    = 8'h48;
    localparam logic [reg_off_w-1:0] reg_lineinc = 8'h50;
    localparam logic [reg_off_w-1:0] reg_status  = 8'h58;

    localparam int en_bit       = 3;            // ctrl enable
    localparam int div_lsb      = 4;            // ctrl pixel_div 9:4
    localparam int underrun_bit = 0;            // status, write 1 to clear

    // h1/v1 hold {size, end}, h2/v2 hold {sync start, sync end}
    localparam int pair_w = 2 * coord_w;

endpackage

`default_nettype wire

// File: verilog/vid_bus_pkg.sv
`default_nettype none

package vid_bus_pkg;

    localparam int axi_addr_w = 32;
    localparam int axi_data_w = 32;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // Pixel word is {R, G, B}
    localparam int rgb_w  = 24;
    localparam int chan_w = 8;
    localparam int r_lsb  = 16;
    localparam int g_lsb  = 8;
    localparam int b_lsb  = 0;

    localparam int fifo_depth = 16;             // Must hold a whole visible line
    localparam int fifo_aw    = $clog2(fifo_depth);

    typedef enum logic [1:0] {fetch_idle, fetch_addr, fetch_data} fetch_state_t;
    typedef enum logic {wr_idle, wr_resp} wr_state_t;

endpackage

`default_nettype wire

// File: verilog/vid_reg_file.sv
`default_nettype none

module vid_reg_file import vid_regs_pkg::*, vid_bus_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic [axi_addr_w-1:0] s_awaddr,
    input  logic                  s_awvalid,
    output logic                  s_awready,
    input  logic [axi_data_w-1:0] s_wdata,
    input  logic                  s_wvalid,
    output logic                  s_wready,
    output logic [1:0]            s_bresp,
    output logic                  s_bvalid,
    input  logic                  s_bready,
    input  logic [axi_addr_w-1:0] s_araddr,
    input  logic                  s_arvalid,
    output logic                  s_arready,
    output logic [axi_data_w-1:0] s_rdata,
    output logic [1:0]            s_rresp,
    output logic                  s_rvalid,
    input  logic                  s_rready,
    input  logic                  underrun_set,
    output logic                  enable,
    output logic [div_w-1:0]      pixel_div,
    output logic [coord_w-1:0]    hend,
    output logic [coord_w-1:0]    hsize,
    output logic [coord_w-1:0]    hsync_start,
    output logic [coord_w-1:0]    hsync_end,
    output logic [coord_w-1:0]    vend,
    output logic [coord_w-1:0]    vsize,
    output logic [coord_w-1:0]    vsync_start,
    output logic [coord_w-1:0]    vsync_end,
    output logic [axi_addr_w-1:0] base,
    output logic [axi_addr_w-1:0] lineinc
);

    function automatic logic is_mapped(input logic [reg_off_w-1:0] off);
        return off inside {reg_ctrl, reg_h1, reg_h2, reg_v1, reg_v2,
                           reg_base, reg_lineinc, reg_status};
    endfunction

    wr_state_t              wr_state;
    logic                   wr_fire;
    logic                   underrun;
    logic [reg_off_w-1:0]   wr_off;
    logic [axi_data_w-1:0]  rd_word;

    assign wr_off    = s_awaddr[reg_off_w-1:0];
    assign wr_fire   = (wr_state == wr_idle) && s_awvalid && s_wvalid; // Address and data together
    assign s_awready = wr_fire;
    assign s_wready  = wr_fire;
    assign s_bvalid  = (wr_state == wr_resp);
    assign s_arready = !s_rvalid;               // One read response at a time

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_state <= wr_idle;
        end else if (wr_state == wr_idle) begin
            if (wr_fire)
                wr_state <= wr_resp;
        end else if (s_bready) begin
            wr_state <= wr_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire)
            s_bresp <= is_mapped(wr_off) ? resp_okay : resp_slverr;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            enable    <= 1'b0;
            pixel_div <= '0;
            {hsize, hend}             <= '0;
            {hsync_start, hsync_end}  <= '0;
            {vsize, vend}             <= '0;
            {vsync_start, vsync_end}  <= '0;
            base      <= '0;
            lineinc   <= '0;
        end else if (wr_fire) begin
            case (wr_off)
                reg_ctrl: begin
                    enable    <= s_wdata[en_bit];
                    pixel_div <= s_wdata[div_lsb +: div_w];
                end
                reg_h1:      {hsize, hend}            <= s_wdata[pair_w-1:0];
                reg_h2:      {hsync_start, hsync_end} <= s_wdata[pair_w-1:0];
                reg_v1:      {vsize, vend}            <= s_wdata[pair_w-1:0];
                reg_v2:      {vsync_start, vsync_end} <= s_wdata[pair_w-1:0];
                reg_base:    base    <= s_wdata;
                reg_lineinc: lineinc <= s_wdata;
                default: ;                      // Status handled below, unmapped ignored
            endcase
        end
    end

    // Sticky underrun, a new event beats the clear
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            underrun <= 1'b0;
        else if (underrun_set)
            underrun <= 1'b1;
        else if (wr_fire && wr_off == reg_status && s_wdata[underrun_bit])
            underrun <= 1'b0;
    end

    always_comb begin
        rd_word = '0;
        case (s_araddr[reg_off_w-1:0])
            reg_ctrl: begin
                rd_word[en_bit]             = enable;
                rd_word[div_lsb +: div_w]   = pixel_div;
            end
            reg_h1:      rd_word[pair_w-1:0] = {hsize, hend};
            reg_h2:      rd_word[pair_w-1:0] = {hsync_start, hsync_end};
            reg_v1:      rd_word[pair_w-1:0] = {vsize, vend};
            reg_v2:      rd_word[pair_w-1:0] = {vsync_start, vsync_end};
            reg_base:    rd_word = base;
            reg_lineinc: rd_word = lineinc;
            reg_status:  rd_word[underrun_bit] = underrun;
            default:     rd_word = '0;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            s_rvalid <= 1'b0;
        else if (s_arvalid && s_arready)
            s_rvalid <= 1'b1;
        else if (s_rready)
            s_rvalid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (s_arvalid && s_arready) begin
            s_rdata <= rd_word;
            s_rresp <= is_mapped(s_araddr[reg_off_w-1:0]) ? resp_okay : resp_slverr;
        end
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!reset_n)
        s_bvalid && !s_bready |=> s_bvalid)
        else $error("bvalid dropped before bready");

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!reset_n)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata))
        else $error("rvalid or rdata changed before rready");

endmodule

`default_nettype wire

// File: verilog/vid_timing.sv
`default_nettype none

module vid_timing import vid_regs_pkg::*; (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               enable,
    input  logic [div_w-1:0]   pixel_div,
    input  logic [coord_w-1:0] hend,
    input  logic [coord_w-1:0] hsize,
    input  logic [coord_w-1:0] hsync_start,
    input  logic [coord_w-1:0] hsync_end,
    input  logic [coord_w-1:0] vend,
    input  logic [coord_w-1:0] vsize,
    input  logic [coord_w-1:0] vsync_start,
    input  logic [coord_w-1:0] vsync_end,
    output logic               hsync,
    output logic               hblank,
    output logic               vsync,
    output logic               vblank,
    output logic               pixel_pop,
    output logic               line_start,
    output logic [coord_w-1:0] fetch_line
);

    logic [div_w-1:0]   div_cnt;
    logic [coord_w-1:0] hcnt;
    logic [coord_w-1:0] vcnt;
    logic               pix_tick;
    logic               period_start;

    assign pix_tick     = enable && (div_cnt == pixel_div);    // Last clock of a pixel period
    assign period_start = enable && (div_cnt == '0);

    assign pixel_pop  = period_start && (hcnt < hsize) && (vcnt < vsize);
    assign line_start = period_start && (hcnt == hsize);       // First clock of hblank
    assign fetch_line = (vcnt == vend) ? '0 : vcnt + 1'b1;

    // Idle counters park in the blank of the last line
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt <= '0;
            hcnt    <= '0;
            vcnt    <= '0;
        end else if (!enable) begin
            div_cnt <= '0;
            hcnt    <= hsize;
            vcnt    <= vend;
        end else if (pix_tick) begin
            div_cnt <= '0;
            if (hcnt == hend) begin
                hcnt <= '0;
                vcnt <= (vcnt == vend) ? '0 : vcnt + 1'b1;
            end else begin
                hcnt <= hcnt + 1'b1;
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Registered one clock behind the counts
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hblank <= 1'b1;
            vblank <= 1'b1;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
        end else if (!enable) begin
            hblank <= 1'b1;
            vblank <= 1'b1;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
        end else begin
            hblank <= (hcnt >= hsize);
            vblank <= (vcnt >= vsize);
            hsync  <= (hcnt >= hsync_start) && (hcnt < hsync_end);
            vsync  <= (vcnt >= vsync_start) && (vcnt < vsync_end);
        end
    end

    a_no_pop_at_line_start: assert property (@(posedge clk) disable iff (!reset_n)
        line_start |-> !pixel_pop ##1 hblank)
        else $error("line_start overlaps active video");

endmodule

`default_nettype wire

// File: verilog/vid_line_fetch.sv
`default_nettype none

module vid_line_fetch import vid_regs_pkg::*, vid_bus_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  line_start,
    input  logic [coord_w-1:0]    fetch_line,
    input  logic [coord_w-1:0]    vsize,
    input  logic [coord_w-1:0]    hsize,
    input  logic [axi_addr_w-1:0] base,
    input  logic [axi_addr_w-1:0] lineinc,
    input  logic                  fifo_full,
    output logic [axi_addr_w-1:0] m_araddr,
    output logic                  m_arvalid,
    input  logic                  m_arready,
    input  logic [axi_data_w-1:0] m_rdata,
    input  logic [1:0]            m_rresp,
    input  logic                  m_rvalid,
    output logic                  m_rready,
    output logic                  fifo_flush,
    output logic                  fifo_push,
    output logic [rgb_w-1:0]      fifo_data
);

    fetch_state_t           state;
    logic [coord_w-1:0]     word_idx;
    logic [axi_addr_w-1:0]  pend_addr;          // Start of the requested line
    logic                   pend;               // Line request waiting for idle
    logic                   drop;               // Beat in flight belongs to a flushed line

    assign fifo_flush = line_start;
    assign m_arvalid  = (state == fetch_addr) && !fifo_full;
    assign m_rready   = (state == fetch_data);
    assign fifo_push  = m_rvalid && m_rready && !drop;
    // Error beats keep the pixel count but show black
    assign fifo_data  = (m_rresp == resp_okay) ? m_rdata[rgb_w-1:0] : '0;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= fetch_idle;
            pend  <= 1'b0;
            drop  <= 1'b0;
        end else begin
            case (state)
                fetch_idle:
                    if (pend)
                        state <= fetch_addr;
                fetch_addr:
                    if (m_arvalid && m_arready)
                        state <= fetch_data;
                fetch_data:
                    if (m_rvalid) begin
                        if (drop || line_start || word_idx == hsize - 1'b1)
                            state <= fetch_idle;
                        else
                            state <= fetch_addr;
                    end
                default: state <= fetch_idle;
            endcase

            if (line_start)
                pend <= (fetch_line < vsize) && (hsize != '0);
            else if (state == fetch_idle)
                pend <= 1'b0;

            if (state == fetch_data && m_rvalid)
                drop <= 1'b0;
            else if (line_start && state != fetch_idle)
                drop <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (line_start)
            pend_addr <= base + lineinc * axi_addr_w'(fetch_line);
        if (state == fetch_idle && pend) begin
            m_araddr <= pend_addr;
            word_idx <= '0;
        end else if (state == fetch_data && m_rvalid) begin
            m_araddr <= m_araddr + 3'd4;        // Next packed word
            word_idx <= word_idx + 1'b1;
        end
    end

    a_no_ar_when_full: assert property (@(posedge clk) disable iff (!reset_n)
        m_arvalid && !m_arready |=> m_arvalid && !fifo_full)
        else $error("arvalid dropped or raised with FIFO full");

endmodule

`default_nettype wire

// File: verilog/vid_pixel_fifo.sv
`default_nettype none

module vid_pixel_fifo import vid_bus_pkg::*; (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             flush,
    input  logic             push,
    input  logic             pop,
    input  logic [rgb_w-1:0] push_data,
    output logic [rgb_w-1:0] pop_data,
    output logic             full,
    output logic             empty
);

    logic [rgb_w-1:0] mem [fifo_depth];
    logic [fifo_aw:0] wr_ptr;                   // Extra bit tells full from empty
    logic [fifo_aw:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign empty    = (wr_ptr == rd_ptr);
    assign full     = (wr_ptr[fifo_aw] != rd_ptr[fifo_aw]) &&
                      (wr_ptr[fifo_aw-1:0] == rd_ptr[fifo_aw-1:0]);
    assign do_push  = push && !full && !flush;
    assign do_pop   = pop && !empty && !flush;
    assign pop_data = mem[rd_ptr[fifo_aw-1:0]]; // Head word shown ahead of pop

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr[fifo_aw-1:0]] <= push_data;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (!reset_n)
        full |-> !push)
        else $error("push into full pixel FIFO");

endmodule

`default_nettype wire

// File: verilog/vid_ctrl_top.sv
`default_nettype none

module vid_ctrl_top import vid_regs_pkg::*, vid_bus_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic [axi_addr_w-1:0] s_awaddr,
    input  logic                  s_awvalid,
    output logic                  s_awready,
    input  logic [axi_data_w-1:0] s_wdata,
    input  logic                  s_wvalid,
    output logic                  s_wready,
    output logic [1:0]            s_bresp,
    output logic                  s_bvalid,
    input  logic                  s_bready,
    input  logic [axi_addr_w-1:0] s_araddr,
    input  logic                  s_arvalid,
    output logic                  s_arready,
    output logic [axi_data_w-1:0] s_rdata,
    output logic [1:0]            s_rresp,
    output logic                  s_rvalid,
    input  logic                  s_rready,
    output logic [axi_addr_w-1:0] m_araddr,
    output logic                  m_arvalid,
    input  logic                  m_arready,
    input  logic [axi_data_w-1:0] m_rdata,
    input  logic [1:0]            m_rresp,
    input  logic                  m_rvalid,
    output logic                  m_rready,
    output logic                  hsync,
    output logic                  hblank,
    output logic                  vsync,
    output logic                  vblank,
    output logic [chan_w-1:0]     r,
    output logic [chan_w-1:0]     g,
    output logic [chan_w-1:0]     b
);

    logic                  enable;
    logic [div_w-1:0]      pixel_div;
    logic [coord_w-1:0]    hend, hsize, hsync_start, hsync_end;
    logic [coord_w-1:0]    vend, vsize, vsync_start, vsync_end;
    logic [axi_addr_w-1:0] base, lineinc;
    logic                  pixel_pop, line_start;
    logic [coord_w-1:0]    fetch_line;
    logic                  fifo_flush, fifo_push, fifo_full, fifo_empty;
    logic [rgb_w-1:0]      fifo_data, pop_data, rgb_q;
    logic                  underrun_set;

    assign underrun_set = pixel_pop && fifo_empty;  // Pixel due but line not fetched
    assign r = rgb_q[r_lsb +: chan_w];
    assign g = rgb_q[g_lsb +: chan_w];
    assign b = rgb_q[b_lsb +: chan_w];

    // Cleared with the blank edge so RGB lines up with hblank
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            rgb_q <= '0;
        else if (!enable || line_start)
            rgb_q <= '0;
        else if (pixel_pop)
            rgb_q <= fifo_empty ? '0 : pop_data;
    end

    vid_reg_file u_regs (.*);

    vid_timing u_timing (.*);

    vid_line_fetch u_fetch (.*);

    vid_pixel_fifo u_fifo (
        .clk       (clk),
        .reset_n   (reset_n),
        .flush     (fifo_flush),
        .push      (fifo_push),
        .pop       (pixel_pop),
        .push_data (fifo_data),
        .pop_data  (pop_data),
        .full      (fifo_full),
        .empty     (fifo_empty)
    );

endmodule

`default_nettype wire

// File: tests/axi_mem_model.sv
`default_nettype none

module axi_mem_model import vid_bus_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_n,
    input  int unsigned           latency,      // Clocks from address to data
    input  logic [axi_addr_w-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [axi_data_w-1:0] rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready
);

    logic                  busy;
    logic [axi_addr_w-1:0] addr_q;
    int unsigned           wait_cnt;

    assign arready = !busy;                     // One read in flight

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy     <= 1'b0;
            rvalid   <= 1'b0;
            rdata    <= '0;
            rresp    <= resp_okay;
            addr_q   <= '0;
            wait_cnt <= 0;
        end else if (!busy) begin
            if (arvalid) begin
                busy     <= 1'b1;
                addr_q   <= araddr;
                wait_cnt <= latency;
            end
        end else if (rvalid) begin
            if (rready) begin
                rvalid <= 1'b0;
                busy   <= 1'b0;
            end
        end else if (wait_cnt <= 1) begin
            rvalid <= 1'b1;
            rdata  <= {8'h00, addr_q[25:2]};    // Word index as the pixel
            rresp  <= resp_okay;
        end else begin
            wait_cnt <= wait_cnt - 1;
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_vid_ctrl.sv
`default_nettype none

module tb_vid_ctrl import vid_regs_pkg::*, vid_bus_pkg::*; ();

    localparam int          clk_period = 40;
    localparam int          total_frames = 7;              // Regs 1, timing 3, disable 1, underrun 2
    localparam logic [27:0] idle_word = {4'b1100, 24'h0};  // {hblank, vblank, hsync, vsync, rgb}

    logic                  clk;
    logic                  reset_n;
    logic [axi_addr_w-1:0] s_awaddr, s_araddr, m_araddr;
    logic [axi_data_w-1:0] s_wdata, s_rdata, m_rdata;
    logic                  s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
    logic                  s_arvalid, s_arready, s_rvalid, s_rready;
    logic [1:0]            s_bresp, s_rresp, m_rresp;
    logic                  m_arvalid, m_arready, m_rvalid, m_rready;
    logic                  hsync, hblank, vsync, vblank;
    logic [chan_w-1:0]     r, g, b;

    integer      seed;
    int unsigned latency;
    string       test_name;
    int unsigned fail_cnt = 0;
    bit          chk_timing = 0;
    bit          chk_pixel = 0;
    bit          chk_off = 0;

    int unsigned mode_div, mode_hsize, mode_hend, mode_hss, mode_hse;
    int unsigned mode_vsize, mode_vend, mode_vss, mode_vse;
    logic [31:0] mode_base, mode_linc;
    int unsigned frame_clks, line_clks;
    int unsigned exp_hs_period, exp_hb_low, exp_hs_high, exp_vb_lines, exp_vs_lines;

    // Monitor state from values seen at the clock edge
    logic        hsync_d = 0, hblank_d = 1, vsync_d = 0, vblank_d = 1;
    logic        hs_rise;
    bit          hs_seen = 0;
    int unsigned hs_gap = 0, hs_high = 0, hb_low = 0, vb_lines = 0, vs_lines = 0;
    int unsigned pc_cnt = 0, ln_cnt = 0;
    logic [rgb_w-1:0] exp_rgb;

    vid_ctrl_top dut0 (.*);

    axi_mem_model u_mem (
        .clk     (clk),
        .reset_n (reset_n),
        .latency (latency),
        .araddr  (m_araddr),
        .arvalid (m_arvalid),
        .arready (m_arready),
        .rdata   (m_rdata),
        .rresp   (m_rresp),
        .rvalid  (m_rvalid),
        .rready  (m_rready)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        fail_cnt++;
        abort_run($sformatf("CHECK FAILED %s, %s: expected 0x%0h, actual 0x%0h",
                            test_name, what, expected, actual));
    endtask

    // Pixel word that the memory holds at a byte address
    function automatic logic [rgb_w-1:0] word_at(input logic [31:0] addr);
        return addr[25:2];
    endfunction

    function automatic logic [31:0] ctrl_word(input bit en);
        logic [31:0] w;
        w = '0;
        w[en_bit] = en;
        w[div_lsb +: div_w] = div_w'(mode_div);
        return w;
    endfunction

    assign hs_rise = hsync && !hsync_d;

    always_comb begin
        exp_rgb = word_at(mode_base + mode_linc * ln_cnt + 32'd4 * (pc_cnt / (mode_div + 1)));
    end

    always @(posedge clk) begin
        hsync_d  <= hsync;
        hblank_d <= hblank;
        vsync_d  <= vsync;
        vblank_d <= vblank;
        hs_gap   <= hs_rise ? 1 : hs_gap + 1;
        hs_seen  <= chk_timing && (hs_seen || hs_rise);
        hs_high  <= hsync ? hs_high + 1 : 0;
        hb_low   <= hblank ? 0 : hb_low + 1;
        vb_lines <= vblank ? 0 : vb_lines + (hs_rise ? 1 : 0);
        vs_lines <= !vsync ? 0 : vs_lines + (hs_rise ? 1 : 0);
        pc_cnt   <= hblank ? 0 : pc_cnt + 1;             // Clocks since hblank fell
        ln_cnt   <= vblank ? 0 : ln_cnt + ((hblank && !hblank_d) ? 1 : 0);
    end

    a_hs_period: assert property (@(posedge clk) disable iff (!reset_n)
        chk_timing && hs_seen && hs_rise |-> hs_gap == exp_hs_period)
        else report_mismatch("hsync period", exp_hs_period, hs_gap);

    a_hb_low: assert property (@(posedge clk) disable iff (!reset_n)
        chk_timing && hblank && !hblank_d |-> hb_low == exp_hb_low)
        else report_mismatch("hblank low clocks", exp_hb_low, hb_low);

    a_hs_high: assert property (@(posedge clk) disable iff (!reset_n)
        chk_timing && !hsync && hsync_d |-> hs_high == exp_hs_high)
        else report_mismatch("hsync high clocks", exp_hs_high, hs_high);

    a_vb_lines: assert property (@(posedge clk) disable iff (!reset_n)
        chk_timing && vblank && !vblank_d |-> vb_lines == exp_vb_lines)
        else report_mismatch("vblank low lines", exp_vb_lines, vb_lines);

    a_vs_lines: assert property (@(posedge clk) disable iff (!reset_n)
        chk_timing && !vsync && vsync_d |-> vs_lines == exp_vs_lines)
        else report_mismatch("vsync high lines", exp_vs_lines, vs_lines);

    a_pixel: assert property (@(posedge clk) disable iff (!reset_n)
        chk_pixel && !hblank && !vblank |-> {r, g, b} == exp_rgb)
        else report_mismatch("pixel rgb", exp_rgb, {r, g, b});

    a_idle: assert property (@(posedge clk) disable iff (!reset_n)
        chk_off |-> {hblank, vblank, hsync, vsync, r, g, b} == idle_word)
        else report_mismatch("idle outputs", idle_word, {hblank, vblank, hsync, vsync, r, g, b});

    task automatic write_reg(input logic [7:0] off, input logic [31:0] data,
                             input logic [1:0] exp_resp);
        logic [1:0] resp;
        @(posedge clk);
        #2;
        s_awaddr  = {24'h0, off};
        s_wdata   = data;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        do @(posedge clk); while (!s_awready);
        assert (s_wready) else report_mismatch("wready with awready", 32'h1, s_wready);
        #2;
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b1;
        do @(posedge clk); while (!s_bvalid);
        resp = s_bresp;
        #2;
        s_bready = 1'b0;
        assert (resp == exp_resp) else report_mismatch("write response", exp_resp, resp);
    endtask

    task automatic read_expect(input logic [7:0] off, input logic [31:0] exp_data,
                               input logic [1:0] exp_resp);
        logic [31:0] data;
        logic [1:0]  resp;
        @(posedge clk);
        #2;
        s_araddr  = {24'h0, off};
        s_arvalid = 1'b1;
        do @(posedge clk); while (!s_arready);
        #2;
        s_arvalid = 1'b0;
        s_rready  = 1'b1;
        do @(posedge clk); while (!s_rvalid);
        data = s_rdata;
        resp = s_rresp;
        #2;
        s_rready = 1'b0;
        assert (resp == exp_resp) else report_mismatch("read response", exp_resp, resp);
        assert (resp != resp_okay || data == exp_data)
            else report_mismatch($sformatf("read data at 0x%0h", off), exp_data, data);
    endtask

    task automatic draw_mode();
        mode_div   = $unsigned($random(seed)) % 4;
        mode_hsize = 4 + $unsigned($random(seed)) % 5;
        mode_hend  = mode_hsize + 27 + $unsigned($random(seed)) % 8;  // 28 to 35 blank pixels
        mode_hss   = mode_hsize + 2 + $unsigned($random(seed)) % 4;
        mode_hse   = mode_hss + 4 + $unsigned($random(seed)) % 8;
        mode_vsize = 2 + $unsigned($random(seed)) % 3;
        mode_vend  = mode_vsize + 3 + $unsigned($random(seed)) % 4;
        mode_vss   = mode_vsize + 1;
        mode_vse   = mode_vss + 1 + $unsigned($random(seed)) % 2;
        mode_base  = $random(seed) & 32'h03FF_FFFC;
        mode_linc  = ($random(seed) & 32'h0000_0FFC) + 32'h40;
        line_clks  = (mode_hend + 1) * (mode_div + 1);
        frame_clks = line_clks * (mode_vend + 1);
        exp_hs_period = line_clks;
        exp_hb_low    = mode_hsize * (mode_div + 1);
        exp_hs_high   = (mode_hse - mode_hss) * (mode_div + 1);
        exp_vb_lines  = mode_vsize;
        exp_vs_lines  = mode_vse - mode_vss;
    endtask

    task automatic check_registers();
        logic [7:0]  offs [7];
        logic [31:0] masks [7];
        logic [31:0] vals [7];
        offs  = '{reg_ctrl, reg_h1, reg_h2, reg_v1, reg_v2, reg_base, reg_lineinc};
        masks = '{32'h0000_03F8, 32'h03FF_FFFF, 32'h03FF_FFFF, 32'h03FF_FFFF,
                  32'h03FF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF};
        for (int i = 0; i < 7; i++) begin
            vals[i] = $random(seed);
            if (i == 0)
                vals[i][en_bit] = 1'b0;                 // Keep the controller stopped
            write_reg(offs[i], vals[i], resp_okay);
        end
        for (int i = 0; i < 7; i++)
            read_expect(offs[i], vals[i] & masks[i], resp_okay);
        read_expect(reg_status, 32'h0, resp_okay);
        write_reg(8'h04, 32'hFFFF_FFFF, resp_slverr);
        read_expect(8'h04, 32'h0, resp_slverr);
        for (int i = 0; i < 7; i++)
            read_expect(offs[i], vals[i] & masks[i], resp_okay);
    endtask

    task automatic program_mode();
        write_reg(reg_h1, {6'h0, coord_w'(mode_hsize), coord_w'(mode_hend)}, resp_okay);
        write_reg(reg_h2, {6'h0, coord_w'(mode_hss), coord_w'(mode_hse)}, resp_okay);
        write_reg(reg_v1, {6'h0, coord_w'(mode_vsize), coord_w'(mode_vend)}, resp_okay);
        write_reg(reg_v2, {6'h0, coord_w'(mode_vss), coord_w'(mode_vse)}, resp_okay);
        write_reg(reg_base, mode_base, resp_okay);
        write_reg(reg_lineinc, mode_linc, resp_okay);
    endtask

    initial begin
        longint limit;
        #1;
        limit = 2 * longint'(frame_clks) * total_frames;
        #(limit * clk_period);
        abort_run("Watchdog timeout, the tests did not finish in time");
    end

    initial begin
        reset_n   = 1'b0;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        latency   = 1;
        seed      = 32'h10fd0976;
        test_name = "reset";
        draw_mode();
        repeat (8) @(posedge clk);
        #2;
        reset_n = 1'b1;

        // Test 1 covers the register map
        test_name = "register access";
        check_registers();

        // Tests 2 to 4 run a few frames with timing and pixel monitors armed
        test_name = "timing and pixel data";
        program_mode();
        write_reg(reg_ctrl, ctrl_word(1'b1), resp_okay);
        chk_timing = 1;
        chk_pixel  = 1;
        repeat (3) @(posedge vsync);
        @(posedge clk);
        #2;
        chk_timing = 0;
        chk_pixel  = 0;

        // Test 5 sends the outputs idle
        test_name = "disable";
        write_reg(reg_ctrl, ctrl_word(1'b0), resp_okay);
        @(posedge clk);
        #2;
        chk_off = 1;
        repeat (line_clks) @(posedge clk);
        #2;
        chk_off = 0;

        // Test 6 starves the FIFO with a slow memory
        test_name = "underrun";
        read_expect(reg_status, 32'h0, resp_okay);
        latency = 40;
        write_reg(reg_ctrl, ctrl_word(1'b1), resp_okay);
        @(negedge vblank);
        @(posedge hblank);                          // First visible line done
        read_expect(reg_status, 32'h1, resp_okay);
        write_reg(reg_ctrl, ctrl_word(1'b0), resp_okay);
        write_reg(reg_status, 32'h1, resp_okay);
        read_expect(reg_status, 32'h0, resp_okay);

        if (fail_cnt == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            abort_run("Checks failed during the run");
        end
    end

endmodule

`default_nettype wire

// File: vid_ctrl.f
verilog/vid_regs_pkg.sv
verilog/vid_bus_pkg.sv
verilog/vid_reg_file.sv
verilog/vid_timing.sv
verilog/vid_line_fetch.sv
verilog/vid_pixel_fifo.sv
verilog/vid_ctrl_top.sv
tests/axi_mem_model.sv
tests/tb_vid_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the vid_ctrl testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f vid_ctrl.f --top-module tb_vid_ctrl \
    -Mdir obj_dir -o sim_vid_ctrl

status=0
output=$(./obj_dir/sim_vid_ctrl 2>&1) || status=$?
echo "$output"

if [ "$status" -eq 0 ] && grep -q "Simulation completed successfully" <<< "$output"; then
    exit 0
fi
exit 1
